/* bpred_params.svh */
// Branch predictor sizing constants shared by the package and the table modules

`ifndef BPRED_PARAMS_SVH
`define BPRED_PARAMS_SVH

// Width of every fetch and target address
`define BP_XLEN 32

// Index bits of the two-bit counter table (64 counters)
`define BP_DIR_BITS 6

// Index bits of the direct-mapped BTB (16 entries)
`define BP_BTB_BITS 4

// Entries in the return address stack
`define BP_RAS_DEPTH 4

// Counter value after reset, weakly not taken
`define BP_COUNTER_RESET 2'b01

`endif

/* bpred_pkg.sv */
// Branch predictor types for addresses, instruction class, predictions and reports
`default_nettype none

`include "bpred_params.svh"

package bpred_pkg;

  // Fetch, target and fall-through addresses
  typedef logic [`BP_XLEN-1:0] pcT;

  // One-hot control class, all zero for ordinary instructions
  typedef struct packed {
    logic call;
    logic ret;
    logic jump;
    logic branch;
  } iClassT;

  // Prediction made in fetch and carried down to execute
  typedef struct packed {
    logic   valid;
    pcT     nextPc;
    // Class as stored in the BTB, zero on a miss
    iClassT iClass;
    // Upper bit of the direction counter
    logic   dirTaken;
  } predT;

  // Resolved outcome of the instruction now in execute
  typedef struct packed {
    logic   valid;
    pcT     pc;
    iClassT iClass;
    // Jumps, calls and returns always resolve taken
    logic   taken;
    pcT     target;
  } resolveT;

  // Memory-stage summary of what went wrong
  typedef struct packed {
    logic bpWrong;
    logic dirWrong;
    logic classWrong;
  } reportT;

endpackage

`default_nettype wire

/* stageReg.sv */
// Pipeline stage register with enable and synchronous clear for any packed payload
`timescale 1ns/100ps
`default_nettype none

module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  // Load strobe, low while the pipeline is stalled
  input  logic    en,
  // Flush, wins over the load
  input  logic    clr,
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      q <= '0;
    end else if (clr) begin
      // Bubble into the next stage
      q <= '0;
    end else if (en) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

/* dirPredictor.sv */
// Bimodal direction predictor built from a table of two-bit saturating counters
`timescale 1ns/100ps
`default_nettype none

`include "bpred_params.svh"

module dirPredictor (
  input  logic            clk,
  input  logic            rstN,
  // Fetch lookup
  input  bpred_pkg::pcT   pcF,
  output logic            dirTakenF,
  // Execute training
  input  logic            train,
  input  bpred_pkg::pcT   pcE,
  input  logic            taken
);

  localparam int numEntries = 1 << `BP_DIR_BITS;

  logic [1:0]              ctrQ [numEntries];
  logic [`BP_DIR_BITS-1:0] idxF;
  logic [`BP_DIR_BITS-1:0] idxE;
  logic [1:0]              ctrE;
  logic [1:0]              ctrNextE;

  //////////////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////////////

  // Bits 1:0 are always zero for 4-byte instructions
  assign idxF = pcF[`BP_DIR_BITS+1:2];
  assign idxE = pcE[`BP_DIR_BITS+1:2];

  // Counters 2 and 3 predict taken
  assign dirTakenF = ctrQ[idxF][1];

  //////////////////////////////////////////////////////////////////////
  // Training
  //////////////////////////////////////////////////////////////////////

  assign ctrE = ctrQ[idxE];

  always_comb begin
    ctrNextE = ctrE;
    // Saturate at strongly taken
    if (taken && ctrE != 2'b11) begin
      ctrNextE = ctrE + 2'b01;
    end
    // Saturate at strongly not taken
    if (!taken && ctrE != 2'b00) begin
      ctrNextE = ctrE - 2'b01;
    end
  end

  // Old value is still visible to a fetch in the training cycle
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < numEntries; i++) begin
        ctrQ[i] <= `BP_COUNTER_RESET;
      end
    end else if (train) begin
      ctrQ[idxE] <= ctrNextE;
    end
  end

endmodule

`default_nettype wire

/* targetBuffer.sv */
// Direct-mapped branch target buffer holding target address and instruction class
`timescale 1ns/100ps
`default_nettype none

`include "bpred_params.svh"

module targetBuffer (
  input  logic                clk,
  input  logic                rstN,
  // Fetch lookup
  input  bpred_pkg::pcT       pcF,
  output logic                hitF,
  output bpred_pkg::pcT       targetF,
  output bpred_pkg::iClassT   iClassF,
  // Execute update
  input  logic                update,
  input  bpred_pkg::resolveT  resolveE
);

  localparam int numEntries = 1 << `BP_BTB_BITS;
  localparam int tagBits    = `BP_XLEN - `BP_BTB_BITS - 2;

  logic [numEntries-1:0]   validQ;
  logic [tagBits-1:0]      tagMem    [numEntries];
  bpred_pkg::pcT           targetMem [numEntries];
  bpred_pkg::iClassT       classMem  [numEntries];

  logic [`BP_BTB_BITS-1:0] idxF;
  logic [tagBits-1:0]      tagF;
  logic [`BP_BTB_BITS-1:0] idxE;
  logic [tagBits-1:0]      tagE;
  logic                    hitE;
  logic                    isCtrlE;
  logic                    writeE;
  logic                    invalidateE;

  //////////////////////////////////////////////////////////////////////
  // Fetch lookup
  //////////////////////////////////////////////////////////////////////

  assign idxF = pcF[`BP_BTB_BITS+1:2];
  assign tagF = pcF[`BP_XLEN-1:`BP_BTB_BITS+2];

  // Tag compare only counts on a valid entry
  assign hitF    = validQ[idxF] && (tagMem[idxF] == tagF);
  assign targetF = targetMem[idxF];
  // Miss reads as a non-control instruction
  assign iClassF = hitF ? classMem[idxF] : '0;

  //////////////////////////////////////////////////////////////////////
  // Execute update
  //////////////////////////////////////////////////////////////////////

  assign idxE = resolveE.pc[`BP_BTB_BITS+1:2];
  assign tagE = resolveE.pc[`BP_XLEN-1:`BP_BTB_BITS+2];

  // Fresh match on the resolved PC, not the carried fetch result
  assign hitE    = validQ[idxE] && (tagMem[idxE] == tagE);
  assign isCtrlE = |resolveE.iClass;

  // Control instruction allocates or refreshes its entry
  assign writeE      = update && isCtrlE;
  // Plain instruction that aliased an entry drops it
  assign invalidateE = update && !isCtrlE && hitE;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validQ <= '0;
    end else if (writeE) begin
      validQ[idxE] <= 1'b1;
    end else if (invalidateE) begin
      validQ[idxE] <= 1'b0;
    end
  end

  // Entry payload, qualified by validQ
  always_ff @(posedge clk) begin
    if (writeE) begin
      tagMem[idxE]    <= tagE;
      targetMem[idxE] <= resolveE.target;
      classMem[idxE]  <= resolveE.iClass;
    end
  end

endmodule

`default_nettype wire

/* returnStack.sv */
// Circular return address stack updated by resolved calls and returns
`timescale 1ns/100ps
`default_nettype none

`include "bpred_params.svh"

module returnStack (
  input  logic                clk,
  input  logic                rstN,
  // Predicted return target for fetch
  output bpred_pkg::pcT       topF,
  // Execute update
  input  logic                update,
  input  bpred_pkg::resolveT  resolveE
);

  localparam int depth   = `BP_RAS_DEPTH;
  localparam int ptrBits = $clog2(depth);

  bpred_pkg::pcT      stackQ [depth];
  logic [ptrBits-1:0] ptrQ;
  logic [ptrBits-1:0] ptrInc;
  logic [ptrBits-1:0] ptrDec;
  logic               push;
  logic               pop;

  //////////////////////////////////////////////////////////////////////
  // Pointer arithmetic
  //////////////////////////////////////////////////////////////////////

  // Pointer names the next free slot and wraps at both ends
  assign ptrInc = (ptrQ == ptrBits'(depth - 1)) ? '0 : ptrQ + 1'b1;
  assign ptrDec = (ptrQ == '0) ? ptrBits'(depth - 1) : ptrQ - 1'b1;

  // Most recent push sits just below the pointer
  assign topF = stackQ[ptrDec];

  // Class is one-hot so call and return never coincide
  assign push = update && resolveE.iClass.call;
  assign pop  = update && resolveE.iClass.ret;

  //////////////////////////////////////////////////////////////////////
  // Stack storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ptrQ <= '0;
      for (int i = 0; i < depth; i++) begin
        stackQ[i] <= '0;
      end
    end else if (push) begin
      // Link address of the call
      stackQ[ptrQ] <= resolveE.pc + bpred_pkg::pcT'(4);
      // Overflow silently overwrites the oldest entry
      ptrQ         <= ptrInc;
    end else if (pop) begin
      ptrQ <= ptrDec;
    end
  end

endmodule

`default_nettype wire

/* bpred.sv */
// Fetch-stage branch predictor with execute-stage checking and memory-stage report
`timescale 1ns/100ps
`default_nettype none

module bpred (
  input  logic                clk,
  input  logic                rstN,
  // Pipeline control for decode, execute and memory registers
  input  logic                stall,
  input  logic                flush,
  // Fetch
  input  logic                fetchValid,
  input  bpred_pkg::pcT       pcF,
  output bpred_pkg::predT     predF,
  // Execute
  input  bpred_pkg::resolveT  resolveE,
  output logic                bpWrongE,
  output bpred_pkg::pcT       pcCorrectE,
  // Memory
  output bpred_pkg::reportT   reportM
);

  logic               dirTakenF;
  logic               btbHitF;
  bpred_pkg::pcT      btbTargetF;
  bpred_pkg::iClassT  btbClassF;
  bpred_pkg::pcT      rasTopF;
  bpred_pkg::pcT      pcPlus4F;
  bpred_pkg::pcT      nextPcF;

  bpred_pkg::predT    predD;
  bpred_pkg::predT    predE;
  bpred_pkg::pcT      pcD;
  bpred_pkg::pcT      pcE;

  logic               stageEn;
  logic               trainE;
  logic               checkE;
  bpred_pkg::reportT  reportE;

  assign stageEn = !stall;

  //////////////////////////////////////////////////////////////////////
  // Fetch prediction
  //////////////////////////////////////////////////////////////////////

  dirPredictor dirPred (
    .clk, .rstN,
    .pcF, .dirTakenF,
    .train(trainE && resolveE.iClass.branch),
    .pcE,
    .taken(resolveE.taken)
  );

  targetBuffer btb (
    .clk, .rstN,
    .pcF, .hitF(btbHitF), .targetF(btbTargetF), .iClassF(btbClassF),
    .update(trainE), .resolveE
  );

  returnStack ras (
    .clk, .rstN,
    .topF(rasTopF),
    .update(trainE), .resolveE
  );

  assign pcPlus4F = pcF + bpred_pkg::pcT'(4);

  // Fall through unless the BTB knows a taken control instruction here
  always_comb begin
    nextPcF = pcPlus4F;
    if (btbHitF) begin
      if (btbClassF.ret) begin
        nextPcF = rasTopF;
      end else if (btbClassF.jump || btbClassF.call) begin
        nextPcF = btbTargetF;
      end else if (btbClassF.branch && dirTakenF) begin
        nextPcF = btbTargetF;
      end
    end
  end

  assign predF.valid    = fetchValid;
  assign predF.nextPc   = nextPcF;
  assign predF.iClass   = btbClassF;
  assign predF.dirTaken = dirTakenF;

  //////////////////////////////////////////////////////////////////////
  // Decode and execute registers
  //////////////////////////////////////////////////////////////////////

  stageReg #(.payloadT(bpred_pkg::predT)) predDReg (
    .clk, .rstN, .en(stageEn), .clr(flush), .d(predF), .q(predD)
  );

  stageReg #(.payloadT(bpred_pkg::pcT)) pcDReg (
    .clk, .rstN, .en(stageEn), .clr(flush), .d(pcF), .q(pcD)
  );

  stageReg #(.payloadT(bpred_pkg::predT)) predEReg (
    .clk, .rstN, .en(stageEn), .clr(flush), .d(predD), .q(predE)
  );

  // Fetch PC lined up with predE, indexes the counter update
  stageReg #(.payloadT(bpred_pkg::pcT)) pcEReg (
    .clk, .rstN, .en(stageEn), .clr(flush), .d(pcD), .q(pcE)
  );

  //////////////////////////////////////////////////////////////////////
  // Execute check and training
  //////////////////////////////////////////////////////////////////////

  // Tables only learn from an execute cycle that completes
  assign trainE = resolveE.valid && !stall;

  // Both sides must describe a real instruction
  assign checkE = resolveE.valid && predE.valid;

  assign pcCorrectE = resolveE.taken ? resolveE.target
                                     : resolveE.pc + bpred_pkg::pcT'(4);

  assign bpWrongE = checkE && (predE.nextPc != pcCorrectE);

  assign reportE.bpWrong    = bpWrongE;
  // Counter disagreed on a branch the BTB already knew as a branch
  assign reportE.dirWrong   = checkE && resolveE.iClass.branch && predE.iClass.branch
                              && (predE.dirTaken != resolveE.taken);
  // Includes cold misses, where the BTB class reads as zero
  assign reportE.classWrong = checkE && (predE.iClass != resolveE.iClass);

  //////////////////////////////////////////////////////////////////////
  // Memory report
  //////////////////////////////////////////////////////////////////////

  stageReg #(.payloadT(bpred_pkg::reportT)) reportMReg (
    .clk, .rstN, .en(stageEn), .clr(flush), .d(reportE), .q(reportM)
  );

endmodule

`default_nettype wire

/* bpred_checker.sv */
// Bound assertions on predictor reset state, stall hold and the wrong strobe reaching the report
`timescale 1ns/100ps
`default_nettype none

module bpred_checker (
  input logic               clk,
  input logic               rstN,
  input logic               stall,
  input logic               flush,
  input logic               bpWrongE,
  input bpred_pkg::predT    predE,
  input bpred_pkg::reportT  reportM
);

  // Running count of failed assertions
  int unsigned assertFails = 0;

  //////////////////////////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////////////////////////

  // Memory stage holds a bubble on the first edge out of reset
  resetReportClear: assert property (@(posedge clk) $rose(rstN) |-> (reportM == '0))
    else begin
      $error("memory report not clear on first edge after reset");
      assertFails = assertFails + 1;
    end

  // Wrong strobe of a completed execute cycle lands in the next memory report
  wrongCarriedToReport: assert property (@(posedge clk) disable iff (!rstN)
    (!stall && !flush) |=> (reportM.bpWrong == $past(bpWrongE)))
    else begin
      $error("memory report does not carry the wrong-prediction strobe");
      assertFails = assertFails + 1;
    end

  // Execute prediction frozen across a stalled edge
  stallHoldsExecute: assert property (@(posedge clk) disable iff (!rstN)
    (stall && !flush) |=> $stable(predE))
    else begin
      $error("execute prediction changed across a stall");
      assertFails = assertFails + 1;
    end

endmodule

`default_nettype wire

/* bpred_tb.sv */
// Trace-driven testbench for the branch predictor with a reference model of its tables
`timescale 1ns/100ps
`default_nettype none

`include "bpred_params.svh"

module bpred_tb;

  localparam int clkHalf     = 5;
  // Outputs are read 1 ns before the rising edge
  localparam int sampleDelay = 4;
  localparam int maxRecs     = 256;
  localparam int dirEntries  = 1 << `BP_DIR_BITS;
  localparam int btbEntries  = 1 << `BP_BTB_BITS;
  localparam int tagBits     = `BP_XLEN - `BP_BTB_BITS - 2;
  localparam int rasDepth    = `BP_RAS_DEPTH;

  logic                clk;
  logic                rstN;
  logic                stall;
  logic                flush;
  logic                fetchValid;
  bpred_pkg::pcT       pcF;
  bpred_pkg::predT     predF;
  bpred_pkg::resolveT  resolveE;
  logic                bpWrongE;
  bpred_pkg::pcT       pcCorrectE;
  bpred_pkg::reportT   reportM;

  // Trace records in file order
  bpred_pkg::pcT       recPc     [$];
  bpred_pkg::iClassT   recClass  [$];
  logic                recTaken  [$];
  bpred_pkg::pcT       recTarget [$];
  logic                recStall  [$];

  // Reference copies of the three tables
  logic [1:0]          refCtr       [dirEntries];
  logic                refBtbValid  [btbEntries];
  logic [tagBits-1:0]  refBtbTag    [btbEntries];
  bpred_pkg::pcT       refBtbTarget [btbEntries];
  bpred_pkg::iClassT   refBtbClass  [btbEntries];
  bpred_pkg::pcT       refRas       [rasDepth];
  int                  refRasPtr;

  // Pipeline occupancy as record indexes with -1 for a bubble
  int                  slotD;
  int                  slotE;
  bpred_pkg::predT     expPredD;
  bpred_pkg::predT     expPredE;
  bpred_pkg::reportT   expReportM;
  int                  fetchIdx;
  logic                stallPending;
  int                  cycleNo;
  int                  maxCycles;
  logic                done;

  bpred dut (
    .clk, .rstN, .stall, .flush,
    .fetchValid, .pcF, .predF,
    .resolveE, .bpWrongE, .pcCorrectE,
    .reportM
  );

  bind bpred bpred_checker bpredChk (
    .clk(clk), .rstN(rstN), .stall(stall), .flush(flush),
    .bpWrongE(bpWrongE), .predE(predE), .reportM(reportM)
  );

  initial begin
    clk = 1'b0;
    forever #(clkHalf) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Error handling and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stopRun();
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic checkPred(input string name, input bpred_pkg::predT exp,
                           input bpred_pkg::predT act);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      stopRun();
    end
  endtask

  task automatic checkPc(input string name, input bpred_pkg::pcT exp,
                         input bpred_pkg::pcT act);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      stopRun();
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s expected %b actual %b", name, exp, act);
      stopRun();
    end
  endtask

  task automatic checkReport(input string name, input bpred_pkg::reportT exp,
                             input bpred_pkg::reportT act);
    if (act !== exp) begin
      $display("FAIL %s expected %b actual %b", name, exp, act);
      stopRun();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Trace file
  //////////////////////////////////////////////////////////////////////

  task automatic loadTrace();
    int          fd;
    int          got;
    string       line;
    logic [31:0] pc;
    logic [31:0] cls;
    logic [31:0] tk;
    logic [31:0] tgt;
    logic [31:0] st;
    fd = $fopen("bpred_testdata.txt", "r");
    if (fd == 0) begin
      $display("ERROR: could not open the trace file bpred_testdata.txt");
      stopRun();
    end
    while (!$feof(fd) && recPc.size() < maxRecs) begin
      line = "";
      got = $fgets(line, fd);
      // Lines starting with # describe the columns
      if (got > 0 && line[0] != "#") begin
        got = $sscanf(line, "%h %h %h %h %h", pc, cls, tk, tgt, st);
        if (got == 5) begin
          recPc.push_back(pc);
          recClass.push_back(bpred_pkg::iClassT'(cls[3:0]));
          recTaken.push_back(tk[0]);
          recTarget.push_back(tgt);
          recStall.push_back(st[0]);
        end
      end
    end
    $fclose(fd);
    if (recPc.size() == 0) begin
      $display("ERROR: the trace file holds no records");
      stopRun();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  task automatic resetModel();
    for (int i = 0; i < dirEntries; i++) begin
      refCtr[i] = `BP_COUNTER_RESET;
    end
    for (int i = 0; i < btbEntries; i++) begin
      refBtbValid[i]  = 1'b0;
      refBtbTag[i]    = '0;
      refBtbTarget[i] = '0;
      refBtbClass[i]  = '0;
    end
    for (int i = 0; i < rasDepth; i++) begin
      refRas[i] = '0;
    end
    refRasPtr    = 0;
    slotD        = -1;
    slotE        = -1;
    expPredD     = '0;
    expPredE     = '0;
    expReportM   = '0;
    fetchIdx     = 0;
    stallPending = 1'b0;
  endtask

  // Next PC from the fetch-time view of the tables
  function automatic bpred_pkg::predT predictFetch(input bpred_pkg::pcT pc, input logic valid);
    bpred_pkg::predT p;
    int              bi;
    int              di;
    logic            hit;
    bi  = int'(pc[`BP_BTB_BITS+1:2]);
    di  = int'(pc[`BP_DIR_BITS+1:2]);
    hit = refBtbValid[bi] && (refBtbTag[bi] == pc[`BP_XLEN-1:`BP_BTB_BITS+2]);
    p.valid    = valid;
    p.iClass   = hit ? refBtbClass[bi] : '0;
    p.dirTaken = refCtr[di][1];
    p.nextPc   = pc + 4;
    if (hit && p.iClass.ret) begin
      p.nextPc = refRas[(refRasPtr + rasDepth - 1) % rasDepth];
    end else if (hit && (p.iClass.jump || p.iClass.call)) begin
      p.nextPc = refBtbTarget[bi];
    end else if (hit && p.iClass.branch && p.dirTaken) begin
      p.nextPc = refBtbTarget[bi];
    end
    return p;
  endfunction

  task automatic trainModel(input bpred_pkg::resolveT r);
    int   bi;
    int   di;
    logic hit;
    bi  = int'(r.pc[`BP_BTB_BITS+1:2]);
    di  = int'(r.pc[`BP_DIR_BITS+1:2]);
    hit = refBtbValid[bi] && (refBtbTag[bi] == r.pc[`BP_XLEN-1:`BP_BTB_BITS+2]);
    // Counters only move on branches
    if (r.iClass.branch) begin
      if (r.taken && refCtr[di] != 2'b11) begin
        refCtr[di] = refCtr[di] + 2'b01;
      end else if (!r.taken && refCtr[di] != 2'b00) begin
        refCtr[di] = refCtr[di] - 2'b01;
      end
    end
    if (|r.iClass) begin
      refBtbValid[bi]  = 1'b1;
      refBtbTag[bi]    = r.pc[`BP_XLEN-1:`BP_BTB_BITS+2];
      refBtbTarget[bi] = r.target;
      refBtbClass[bi]  = r.iClass;
    end else if (hit) begin
      refBtbValid[bi] = 1'b0;
    end
    if (r.iClass.call) begin
      refRas[refRasPtr] = r.pc + 4;
      refRasPtr         = (refRasPtr + 1) % rasDepth;
    end else if (r.iClass.ret) begin
      refRasPtr = (refRasPtr + rasDepth - 1) % rasDepth;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Trace player advancing one pipeline cycle per call
  //////////////////////////////////////////////////////////////////////

  task automatic playCycle();
    bpred_pkg::predT    expF;
    bpred_pkg::resolveT res;
    bpred_pkg::pcT      expCorrect;
    bpred_pkg::reportT  expReportE;
    logic               expWrong;
    logic               stallNow;
    logic               fetching;
    string              eName;
    stallNow = stallPending;
    fetching = (fetchIdx < recPc.size());
    // Stalled fetch is presented again next cycle
    stall      = stallNow;
    fetchValid = fetching;
    pcF        = fetching ? recPc[fetchIdx] : '0;
    // Resolution stays up for the whole stay in execute
    res = '0;
    if (slotE >= 0) begin
      res.valid  = 1'b1;
      res.pc     = recPc[slotE];
      res.iClass = recClass[slotE];
      res.taken  = recTaken[slotE];
      res.target = recTarget[slotE];
    end
    resolveE = res;
    eName    = (slotE >= 0) ? $sformatf("record %0d", slotE) : "bubble";

    expF       = predictFetch(pcF, fetching);
    expCorrect = res.taken ? res.target : res.pc + 4;
    expWrong   = res.valid && expPredE.valid && (expPredE.nextPc != expCorrect);
    expReportE.bpWrong    = expWrong;
    expReportE.dirWrong   = res.valid && expPredE.valid && res.iClass.branch
                            && expPredE.iClass.branch && (expPredE.dirTaken != res.taken);
    expReportE.classWrong = res.valid && expPredE.valid && (expPredE.iClass != res.iClass);

    #(sampleDelay);
    checkPred($sformatf("fetch of record %0d", fetchIdx), expF, predF);
    checkBit({eName, " wrong strobe"}, expWrong, bpWrongE);
    checkPc({eName, " corrected pc"}, expCorrect, pcCorrectE);
    checkReport($sformatf("memory report in cycle %0d", cycleNo), expReportM, reportM);
    if (dut.bpredChk.assertFails != 0) begin
      $display("ERROR: a bound assertion failed in cycle %0d", cycleNo);
      stopRun();
    end

    // Advance the model across the coming rising edge
    if (!stallNow) begin
      if (res.valid) begin
        trainModel(res);
      end
      expReportM   = expReportE;
      slotE        = slotD;
      expPredE     = expPredD;
      slotD        = fetching ? fetchIdx : -1;
      expPredD     = expF;
      stallPending = fetching && recStall[fetchIdx];
      if (fetching) begin
        fetchIdx++;
      end
    end else begin
      stallPending = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rstN       = 1'b0;
    stall      = 1'b0;
    flush      = 1'b0;
    fetchValid = 1'b0;
    pcF        = '0;
    resolveE   = '0;
    resetModel();
    loadTrace();
    maxCycles = 4 * recPc.size() + 20;

    repeat (4) @(negedge clk);
    rstN = 1'b1;

    cycleNo = 0;
    done    = 1'b0;
    while (!done) begin
      if (cycleNo >= maxCycles) begin
        $display("ERROR: trace did not drain within %0d cycles", maxCycles);
        stopRun();
      end
      // Last pass only checks the final report
      done = (fetchIdx == recPc.size()) && (slotD < 0) && (slotE < 0);
      playCycle();
      cycleNo++;
      @(negedge clk);
    end

    if (dut.bpredChk.assertFails == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("ERROR: %0d bound assertion failures", dut.bpredChk.assertFails);
      stopRun();
    end
  end

endmodule

`default_nettype wire

/* bpred_testdata.txt */
# pc class taken target stall, all hex, one instruction per line
# class bits are call ret jump branch (8 4 2 1), stall holds the pipeline one cycle
00000040 0 0 00000000 0
00000044 0 0 00000000 0
00000100 1 1 00000200 0
00000204 0 0 00000000 0
00000208 0 0 00000000 0
00000100 1 1 00000200 0
00000204 0 0 00000000 1
00000208 0 0 00000000 0
00000100 1 0 00000200 0
00000104 0 0 00000000 0
00000108 0 0 00000000 0
00000100 1 0 00000200 0
00000104 0 0 00000000 0
00000108 0 0 00000000 0
00000100 1 0 00000200 0
00000104 0 0 00000000 0
00000310 8 1 00000400 0
00000400 0 0 00000000 0
00000420 8 1 00000500 0
00000500 0 0 00000000 0
00000504 0 0 00000000 0
00000508 4 1 00000424 0
00000424 0 0 00000000 0
00000428 0 0 00000000 0
0000042c 4 1 00000314 0
00000314 0 0 00000000 0
00000310 8 1 00000400 0
00000400 0 0 00000000 0
00000420 8 1 00000500 0
00000500 0 0 00000000 1
00000504 0 0 00000000 0
00000508 4 1 00000424 0
00000424 0 0 00000000 0
00000428 0 0 00000000 0
0000042c 4 1 00000314 0
00000314 0 0 00000000 0
00000608 2 1 00000700 0
00000700 0 0 00000000 0
00000704 0 0 00000000 0
00000608 0 0 00000000 0
0000060c 0 0 00000000 0
00000610 0 0 00000000 0
00000608 0 0 00000000 0
0000060c 0 0 00000000 1

/* bpred.f */
+incdir+.
bpred_pkg.sv
stageReg.sv
dirPredictor.sv
targetBuffer.sv
returnStack.sv
bpred.sv
bpred_checker.sv
bpred_tb.sv
